//--- sources.f
hdl/cp0_pkg.sv
hdl/exception.sv
hdl/cp0_regs.sv
hdl/cp0_write_arbiter.sv
hdl/cp0_apb_slave.sv
hdl/cp0_top.sv
verification/cp0_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := cp0_tb
FILELIST   := sources.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TB PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/cp0_tb.sv
`default_nettype none

module cp0_tb;
   timeunit 1ns;
   timeprecision 1ps;

   import cp0_pkg::*;

   // Non-default vector to show the parameter reaches the prioritizer
   localparam logic [31:0] vector = 32'h8000_0180;

   logic        clk, reset;
   logic [5:0]  int_hard;
   logic        ri, brk, syscall, overflow;
   logic        addr_error_sw, addr_error_lw, pc_error, eret;
   logic [31:0] pc_m, alu_out_m;
   exc_type_e   except_type;
   logic        flush_except, pc_trap;
   logic [31:0] pc_except;
   logic        psel, penable, pwrite, pready, pslverr;
   logic [31:0] paddr, pwdata, prdata;

   // Reference copy of the CP0 state
   logic [31:0] status_ref, epc_ref, badv_ref;
   logic [4:0]  code_ref;
   logic [1:0]  ipsw_ref;
   int          mismatches, timeouts, protocol_errs;
   int          seed;
   time         last_done, last_commit;

   cp0_top #(.exc_vector(vector)) uut (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Flush and trap move together and the bus never reports an error
   assert property (@(posedge clk) disable iff (reset) (flush_except == pc_trap) && !pslverr)
   else begin
      protocol_errs++;
      $display("flush_except and pc_trap disagree or pslverr raised at %0t", $time);
   end

   ////////////////////////////////////////////////////////////
   // Checking helpers
   ////////////////////////////////////////////////////////////

   task automatic compare_word(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      assert (got === exp)
      else begin
         mismatches++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // Priority rule highest first with the interrupt gated by IE, EXL and IM
   function automatic exc_type_e predict_type();
      logic [7:0] ip;
      ip = {int_hard, ipsw_ref};
      if (status_ref[0] && !status_ref[1] && |(status_ref[15:8] & ip)) return EXC_INT;
      if (addr_error_lw || pc_error) return EXC_ADEL;
      if (ri) return EXC_RI;
      if (syscall) return EXC_SYS;
      if (brk) return EXC_BP;
      if (addr_error_sw) return EXC_ADES;
      if (overflow) return EXC_OV;
      if (eret) return EXC_ERET;
      return EXC_NOEXC;
   endfunction

   // Redirect check at the edge and then the commit in the reference
   task automatic sample_redirect(input exc_type_e exp);
      logic [31:0] exp_pc;
      logic        taken;
      exp_pc = (exp == EXC_NOEXC) ? 32'h0 : ((exp == EXC_ERET) ? epc_ref : vector);
      taken = (exp != EXC_NOEXC);
      @(posedge clk);
      compare_word("except_type", {27'd0, except_type}, {27'd0, exp});
      compare_word("flush_except", {31'd0, flush_except}, {31'd0, taken});
      compare_word("pc_trap", {31'd0, pc_trap}, {31'd0, taken});
      compare_word("pc_except", pc_except, exp_pc);
      if (taken && exp != EXC_ERET) begin
         epc_ref = pc_m;
         code_ref = exp;
         status_ref[1] = 1'b1;
         if (exp == EXC_ADEL || exp == EXC_ADES) badv_ref = pc_error ? pc_m : alu_out_m;
         last_commit = $time;
      end else if (exp == EXC_ERET) begin
         status_ref[1] = 1'b0;
      end
   endtask

   // Event bits ri brk syscall overflow ades adel_lw pc_error eret from the LSB up
   task automatic apply_events(input logic [7:0] ev, input logic [5:0] lines,
                               input logic [31:0] pc, input logic [31:0] addr);
      @(negedge clk);
      {eret, pc_error, addr_error_lw, addr_error_sw, overflow, syscall, brk, ri} = ev;
      int_hard = lines;
      pc_m = pc;
      alu_out_m = addr;
      sample_redirect(predict_type());
   endtask

   task automatic clear_events();
      @(negedge clk);
      {eret, pc_error, addr_error_lw, addr_error_sw, overflow, syscall, brk, ri} = 8'd0;
      int_hard = 6'd0;
   endtask

   ////////////////////////////////////////////////////////////
   // APB host
   ////////////////////////////////////////////////////////////

   task automatic write_reg(input logic [4:0] num, input logic [31:0] data);
      int waits;
      @(negedge clk);
      psel = 1'b1;
      penable = 1'b0;
      pwrite = 1'b1;
      paddr = {25'd0, num, 2'b00};
      pwdata = data;
      @(negedge clk);
      penable = 1'b1;
      waits = 0;
      @(posedge clk);
      while (!pready && waits < 16) begin
         waits++;
         @(posedge clk);
      end
      last_done = $time;
      if (!pready) begin
         timeouts++;
         $display("write to register %0d never got pready at %0t", num, $time);
      end
      @(negedge clk);
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
   endtask

   task automatic read_expect(input logic [4:0] num, input string name,
                              input logic [31:0] exp);
      int waits;
      @(negedge clk);
      psel = 1'b1;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = {25'd0, num, 2'b00};
      @(negedge clk);
      penable = 1'b1;
      waits = 0;
      @(posedge clk);
      while (!pready && waits < 16) begin
         waits++;
         @(posedge clk);
      end
      if (!pready) begin
         timeouts++;
         $display("read of register %0d never got pready at %0t", num, $time);
      end else begin
         compare_word(name, prdata, exp);
      end
      @(negedge clk);
      psel = 1'b0;
      penable = 1'b0;
   endtask

   // Hardware IP bits must have been quiet for a cycle
   task automatic verify_regs();
      read_expect(CP0_STATUS, "status", status_ref);
      read_expect(CP0_CAUSE, "cause", {16'd0, 6'd0, ipsw_ref, 1'b0, code_ref, 2'b00});
      read_expect(CP0_EPC, "epc", epc_ref);
      read_expect(CP0_BADVADDR, "badvaddr", badv_ref);
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial begin
      logic [31:0] r;
      seed = 65332;
      {mismatches, timeouts, protocol_errs} = {32'd0, 32'd0, 32'd0};
      {status_ref, epc_ref, badv_ref, code_ref, ipsw_ref} = '0;
      last_done = 0;
      last_commit = 0;
      reset = 1'b1;
      int_hard = 6'd0;
      {eret, pc_error, addr_error_lw, addr_error_sw, overflow, syscall, brk, ri} = 8'd0;
      pc_m = 32'd0;
      alu_out_m = 32'd0;
      {psel, penable, pwrite} = 3'b000;
      paddr = 32'd0;
      pwdata = 32'd0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(posedge clk);
      compare_word("pready", {31'd0, pready}, 32'd0);
      compare_word("reg_we", {31'd0, uut.reg_we}, 32'd0);
      verify_regs();

      // Random events with interrupts disabled and each event about one in four
      for (int i = 0; i < 40; i++) begin
         r = $random(seed);
         apply_events(r[7:0] & r[15:8], r[21:16], $random(seed), $random(seed));
      end
      clear_events();
      verify_regs();

      // Writable fields only
      write_reg(CP0_STATUS, 32'hffff_ffff);
      status_ref = 32'h0000_ff03;
      read_expect(CP0_STATUS, "status", status_ref);
      write_reg(CP0_CAUSE, 32'hffff_ffff);
      ipsw_ref = 2'b11;
      verify_regs();
      write_reg(CP0_CAUSE, 32'h0);
      ipsw_ref = 2'b00;
      write_reg(CP0_STATUS, 32'h0);
      status_ref = 32'h0;
      write_reg(CP0_EPC, 32'h1234_5678);
      epc_ref = 32'h1234_5678;
      write_reg(CP0_BADVADDR, 32'hdead_beef);
      verify_regs();
      read_expect(5'd3, "unmapped", 32'h0);
      write_reg(5'd20, 32'h5555_aaaa);
      read_expect(5'd20, "unmapped", 32'h0);

      // Hardware line 0 unmasked through IM bit 10
      write_reg(CP0_STATUS, 32'h0000_0401);
      status_ref = 32'h0000_0401;
      apply_events(8'd0, 6'b000010, 32'h0040_0ff0, 32'h0);
      apply_events(8'd0, 6'b000001, 32'h0040_1000, 32'h0);
      // EXL now holds it off
      apply_events(8'd0, 6'b000001, 32'h0040_1004, 32'h0);
      clear_events();
      verify_regs();

      // Software line 0 unmasked and line 1 masked
      write_reg(CP0_STATUS, 32'h0000_0101);
      status_ref = 32'h0000_0101;
      write_reg(CP0_CAUSE, 32'h0000_0200);
      ipsw_ref = 2'b10;
      sample_redirect(predict_type());
      write_reg(CP0_CAUSE, 32'h0000_0100);
      ipsw_ref = 2'b01;
      sample_redirect(predict_type());
      write_reg(CP0_CAUSE, 32'h0);
      ipsw_ref = 2'b00;
      verify_regs();

      // Commit of store fault, fetch fault, then a syscall
      apply_events(8'b0001_0000, 6'd0, 32'h0040_2000, 32'h1000_0003);
      clear_events();
      verify_regs();
      apply_events(8'b0100_0000, 6'd0, 32'h0040_3001, 32'h2000_0000);
      clear_events();
      verify_regs();
      apply_events(8'b0000_0100, 6'd0, 32'h0040_4000, 32'h3000_0000);
      clear_events();
      verify_regs();

      // Return to EPC
      apply_events(8'b1000_0000, 6'd0, 32'h0040_5000, 32'h0);
      clear_events();
      verify_regs();

      // APB write against three back-to-back commits
      fork
         write_reg(CP0_EPC, 32'hcafe_f00d);
         begin
            apply_events(8'b0000_0100, 6'd0, 32'h0040_6000, 32'h0);
            apply_events(8'b0000_0100, 6'd0, 32'h0040_6004, 32'h0);
            apply_events(8'b0000_0100, 6'd0, 32'h0040_6008, 32'h0);
            clear_events();
         end
      join
      epc_ref = 32'hcafe_f00d;
      assert (last_done > last_commit)
      else begin
         protocol_errs++;
         $display("APB write finished at %0t before the last commit", last_done);
      end
      verify_regs();

      $display("closing counts: %0d mismatches, %0d timeouts, %0d protocol errors",
               mismatches, timeouts, protocol_errs);
      if (mismatches + timeouts + protocol_errs == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- hdl/cp0_top.sv
`default_nettype none

module cp0_top #(
   parameter logic [31:0] exc_vector = 32'hbfc0_0380
) (
   input  logic                clk,
   input  logic                reset,
   // Memory stage events
   input  logic [5:0]          int_hard,
   input  logic                ri,
   input  logic                brk,
   input  logic                syscall,
   input  logic                overflow,
   input  logic                addr_error_sw,
   input  logic                addr_error_lw,
   input  logic                pc_error,
   input  logic                eret,
   input  logic [31:0]         pc_m,
   input  logic [31:0]         alu_out_m,
   // Redirect to fetch
   output cp0_pkg::exc_type_e  except_type,
   output logic                flush_except,
   output logic [31:0]         pc_except,
   output logic                pc_trap,
   // Debug host APB
   input  logic                psel,
   input  logic                penable,
   input  logic                pwrite,
   input  logic [31:0]         paddr,
   input  logic [31:0]         pwdata,
   output logic                pready,
   output logic [31:0]         prdata,
   output logic                pslverr
);

   logic [31:0] status, cause, epc, badvaddr_m;
   logic        wr_req, wr_grant, reg_we;
   logic [4:0]  wr_addr, reg_addr, rd_addr;
   logic [31:0] wr_data, reg_wdata, rd_data;

   ////////////////////////////////////////////////////////////
   // Exception path
   ////////////////////////////////////////////////////////////

   exception #(.exc_vector(exc_vector)) u_exception (
      .int_hard, .ri, .brk, .syscall, .overflow,
      .addr_error_sw, .addr_error_lw, .pc_error, .eret,
      .status, .cause, .epc, .pc_m, .alu_out_m,
      .except_type, .flush_except, .pc_except, .pc_trap, .badvaddr_m
   );

   cp0_regs u_regs (
      .clk, .reset, .int_hard, .except_type, .pc_m, .badvaddr_m,
      .reg_we, .reg_addr, .reg_wdata, .rd_addr,
      .rd_data, .status, .cause, .epc
   );

   // Shared write port with the exception side first
   cp0_write_arbiter u_arbiter (
      .clk, .reset, .flush_except, .except_type,
      .wr_req, .wr_addr, .wr_data,
      .wr_grant, .reg_we, .reg_addr, .reg_wdata
   );

   cp0_apb_slave u_apb (
      .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
      .wr_grant, .rd_data, .pready, .prdata, .pslverr,
      .wr_req, .wr_addr, .wr_data, .rd_addr
   );

endmodule

`default_nettype wire

//--- hdl/cp0_apb_slave.sv
`default_nettype none

module cp0_apb_slave (
   input  logic         clk,
   input  logic         reset,
   input  logic         psel,
   input  logic         penable,
   input  logic         pwrite,
   input  logic [31:0]  paddr,
   input  logic [31:0]  pwdata,
   input  logic         wr_grant,
   input  logic [31:0]  rd_data,
   output logic         pready,
   output logic [31:0]  prdata,
   output logic         pslverr,
   output logic         wr_req,
   output logic [4:0]   wr_addr,
   output logic [31:0]  wr_data,
   output logic [4:0]   rd_addr
);

   // SETUP means a setup cycle was seen, so the next is the first access
   typedef enum logic [1:0] {IDLE, SETUP, ACCESS} apb_state_e;

   apb_state_e state_q;
   apb_state_e state_d;
   logic       access;
   logic       done;

   assign access = psel && penable && (state_q != IDLE);
   // Reads end on the first access and writes once granted
   assign done = access && (pwrite ? wr_grant : (state_q == SETUP));

   ////////////////////////////////////////////////////////////
   // Phase tracking
   ////////////////////////////////////////////////////////////

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE:   if (psel && !penable) state_d = SETUP;
         SETUP:  if (done) state_d = IDLE;
                 else if (access) state_d = ACCESS;
         ACCESS: if (done || !psel) state_d = IDLE;
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) state_q <= IDLE;
      else       state_q <= state_d;
   end

   assign pready  = done;
   assign pslverr = 1'b0;

   // Request stays up from setup until the grant
   assign wr_req  = psel && pwrite;
   assign wr_addr = paddr[6:2];
   assign wr_data = pwdata;

   // Read path straight from the register file
   assign rd_addr = paddr[6:2];
   assign prdata  = (psel && !pwrite) ? rd_data : '0;

endmodule

`default_nettype wire

//--- hdl/cp0_write_arbiter.sv
`default_nettype none

module cp0_write_arbiter (
   input  logic                clk,
   input  logic                reset,
   input  logic                flush_except,
   input  cp0_pkg::exc_type_e  except_type,
   input  logic                wr_req,
   input  logic [4:0]          wr_addr,
   input  logic [31:0]         wr_data,
   output logic                wr_grant,
   output logic                reg_we,
   output logic [4:0]          reg_addr,
   output logic [31:0]         reg_wdata
);

   import cp0_pkg::*;

   logic commit;
   logic eret_now;
   logic block;
   logic grant_q;

   // Exception side owns the update cycle
   assign commit   = flush_except && (except_type != EXC_ERET)
                  && (except_type != EXC_NOEXC);
   // ERET touches Status, so it blocks too
   assign eret_now = flush_except && (except_type == EXC_ERET);
   assign block    = commit || eret_now;

   ////////////////////////////////////////////////////////////
   // Grant
   ////////////////////////////////////////////////////////////

   // Armed from the setup cycle and held while blocked
   always_ff @(posedge clk) begin
      if (reset) begin
         grant_q <= 1'b0;
      end else begin
         grant_q <= wr_req && !wr_grant;
      end
   end

   // Lose the slot in any cycle the exception side writes
   assign wr_grant = grant_q && wr_req && !block;

   // Forward the held APB write
   assign reg_we    = wr_grant;
   assign reg_addr  = wr_addr;
   assign reg_wdata = wr_data;

endmodule

`default_nettype wire

//--- hdl/cp0_regs.sv
`default_nettype none

module cp0_regs (
   input  logic                clk,
   input  logic                reset,
   input  logic [5:0]          int_hard,
   input  cp0_pkg::exc_type_e  except_type,
   input  logic [31:0]         pc_m,
   input  logic [31:0]         badvaddr_m,
   input  logic                reg_we,
   input  logic [4:0]          reg_addr,
   input  logic [31:0]         reg_wdata,
   input  logic [4:0]          rd_addr,
   output logic [31:0]         rd_data,
   output logic [31:0]         status,
   output logic [31:0]         cause,
   output logic [31:0]         epc
);

   import cp0_pkg::*;

   logic [31:0] status_q;
   logic [4:0]  exc_code_q;
   logic [1:0]  ip_sw_q;
   logic [5:0]  ip_hw_q;
   logic [31:0] epc_q;
   logic [31:0] badvaddr_q;
   logic        commit;
   logic        addr_fault;

   // Architectural exception taken this cycle
   assign commit = (except_type != EXC_NOEXC) && (except_type != EXC_ERET);
   assign addr_fault = (except_type == EXC_ADEL) || (except_type == EXC_ADES);

   ////////////////////////////////////////////////////////////
   // Register update
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         status_q   <= '0;
         exc_code_q <= '0;
         ip_sw_q    <= '0;
         ip_hw_q    <= '0;
         epc_q      <= '0;
         badvaddr_q <= '0;
      end else begin
         // Pending hardware lines shown in Cause
         ip_hw_q <= int_hard;
         if (commit) begin
            epc_q      <= pc_m;
            exc_code_q <= except_type;
            status_q[STATUS_EXL] <= 1'b1;
            if (addr_fault) begin
               badvaddr_q <= badvaddr_m;
            end
         end else if (except_type == EXC_ERET) begin
            // Leave handler level
            status_q[STATUS_EXL] <= 1'b0;
         end else if (reg_we) begin
            case (reg_addr)
               CP0_STATUS: status_q <= reg_wdata & STATUS_WMASK;
               CP0_CAUSE:  ip_sw_q  <= reg_wdata[CAUSE_IP_SW_HI:CAUSE_IP_SW_LO];
               CP0_EPC:    epc_q    <= reg_wdata;
               // BadVAddr and unmapped numbers drop the write
               default: ;
            endcase
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Cause assembly and read port
   ////////////////////////////////////////////////////////////

   always_comb begin
      cause = '0;
      cause[CAUSE_EXC_HI:CAUSE_EXC_LO]     = exc_code_q;
      cause[CAUSE_IP_SW_HI:CAUSE_IP_SW_LO] = ip_sw_q;
      cause[CAUSE_IP_HW_HI:CAUSE_IP_HW_LO] = ip_hw_q;
   end

   assign status = status_q;
   assign epc    = epc_q;

   // Unmapped numbers read as zero
   always_comb begin
      case (rd_addr)
         CP0_BADVADDR: rd_data = badvaddr_q;
         CP0_STATUS:   rd_data = status_q;
         CP0_CAUSE:    rd_data = cause;
         CP0_EPC:      rd_data = epc_q;
         default:      rd_data = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- hdl/exception.sv
`default_nettype none

module exception #(
   parameter logic [31:0] exc_vector = 32'hbfc0_0380
) (
   input  logic [5:0]          int_hard,
   input  logic                ri,
   input  logic                brk,
   input  logic                syscall,
   input  logic                overflow,
   input  logic                addr_error_sw,
   input  logic                addr_error_lw,
   input  logic                pc_error,
   input  logic                eret,
   input  logic [31:0]         status,
   input  logic [31:0]         cause,
   input  logic [31:0]         epc,
   input  logic [31:0]         pc_m,
   input  logic [31:0]         alu_out_m,
   output cp0_pkg::exc_type_e  except_type,
   output logic                flush_except,
   output logic [31:0]         pc_except,
   output logic                pc_trap,
   output logic [31:0]         badvaddr_m
);

   import cp0_pkg::*;

   logic       int_pending;
   logic [7:0] ip_all;

   // Hardware lines go straight in and software bits come from Cause
   assign ip_all = {int_hard, cause[CAUSE_IP_SW_HI:CAUSE_IP_SW_LO]};

   // Enabled, not already in a handler, and unmasked
   assign int_pending = status[STATUS_IE] && !status[STATUS_EXL]
                     && |(status[STATUS_IM_HI:STATUS_IM_LO] & ip_all);

   ////////////////////////////////////////////////////////////
   // Priority pick with the highest first
   ////////////////////////////////////////////////////////////

   always_comb begin
      if (int_pending)                         except_type = EXC_INT;
      else if (addr_error_lw || pc_error)      except_type = EXC_ADEL;
      else if (ri)                             except_type = EXC_RI;
      else if (syscall)                        except_type = EXC_SYS;
      else if (brk)                            except_type = EXC_BP;
      else if (addr_error_sw)                  except_type = EXC_ADES;
      else if (overflow)                       except_type = EXC_OV;
      else if (eret)                           except_type = EXC_ERET;
      else                                     except_type = EXC_NOEXC;
   end

   // Redirect target
   assign pc_except = (except_type == EXC_NOEXC) ? 32'h0 :
                      (except_type == EXC_ERET)  ? epc   : exc_vector;

   assign flush_except = (except_type != EXC_NOEXC);
   assign pc_trap      = (except_type != EXC_NOEXC);

   // Fetch fault reports the PC and a data fault the computed address
   assign badvaddr_m = pc_error ? pc_m : alu_out_m;

endmodule

`default_nettype wire

//--- hdl/cp0_pkg.sv
`default_nettype none

package cp0_pkg;

   ////////////////////////////////////////////////////////////
   // Exception kinds
   ////////////////////////////////////////////////////////////

   // Architectural kinds carry their MIPS ExcCode
   typedef enum logic [4:0] {
      EXC_INT   = 5'd0,
      EXC_ADEL  = 5'd4,
      EXC_ADES  = 5'd5,
      EXC_SYS   = 5'd8,
      EXC_BP    = 5'd9,
      EXC_RI    = 5'd10,
      EXC_OV    = 5'd12,
      // Internal kinds on unused codes
      EXC_ERET  = 5'd14,
      EXC_NOEXC = 5'd31
   } exc_type_e;

   ////////////////////////////////////////////////////////////
   // Register numbers and field positions
   ////////////////////////////////////////////////////////////

   // Word index of the APB address
   typedef enum logic [4:0] {
      CP0_BADVADDR = 5'd8,
      CP0_STATUS   = 5'd12,
      CP0_CAUSE    = 5'd13,
      CP0_EPC      = 5'd14
   } cp0_addr_e;

   // Status fields
   localparam int STATUS_IE     = 0;
   localparam int STATUS_EXL    = 1;
   localparam int STATUS_IM_LO  = 8;
   localparam int STATUS_IM_HI  = 15;

   // IE, EXL and IM are the only live Status bits
   localparam logic [31:0] STATUS_WMASK = 32'h0000_ff03;

   // Cause fields
   localparam int CAUSE_EXC_LO   = 2;
   localparam int CAUSE_EXC_HI   = 6;
   localparam int CAUSE_IP_SW_LO = 8;
   localparam int CAUSE_IP_SW_HI = 9;
   localparam int CAUSE_IP_HW_LO = 10;
   localparam int CAUSE_IP_HW_HI = 15;

endpackage

`default_nettype wire
